/* rtl/cbm2_loader_pkg.sv */
package cbm2_loader_pkg;

	// ============================================================
	// Widths
	// ============================================================

	// Byte address in external memory, bits 24..16 select the segment
	typedef logic [24:0] mem_addr_t;
	typedef logic [7:0]  mem_data_t;
	typedef logic [5:0]  ld_index_t;
	typedef logic [8:0]  seg_t;

	// One flag per 8 KB bank of the ROM segment
	typedef logic [7:0]  rom_mask_t;

	// ============================================================
	// Download index codes
	// ============================================================

	localparam ld_index_t IDX_PRG  = 6'd9;
	localparam ld_index_t IDX_ROM1 = 6'd8;
	localparam ld_index_t IDX_ROM2 = 6'd7;
	localparam ld_index_t IDX_ROM4 = 6'd6;
	localparam ld_index_t IDX_ROM6 = 6'd5;
	localparam ld_index_t IDX_ROM8 = 6'd4;
	localparam ld_index_t IDX_ROMC = 6'd3;
	localparam ld_index_t IDX_ROME = 6'd2;

	// In-segment start address per ROM index
	localparam logic [15:0] ROM_BASE [0:63] = '{
		IDX_ROM1: 16'h1000,
		IDX_ROM2: 16'h2000,
		IDX_ROM4: 16'h4000,
		IDX_ROM6: 16'h6000,
		IDX_ROM8: 16'h8000,
		IDX_ROMC: 16'hC000,
		IDX_ROME: 16'hE000,
		default:  16'h0000
	};

	// ROM writes end when address bits 15..12 reach this
	localparam logic [3:0] ROM_STOP_NIBBLE = 4'hD;

	// BASIC text pointers in zero page
	localparam logic [7:0] PTR_TXTTAB = 8'h2D;
	localparam logic [7:0] PTR_TXTEND = 8'h2F;

	typedef enum logic [2:0] {
		PASS,
		PTR_START_LO,
		PTR_START_HI,
		PTR_END_LO,
		PTR_END_HI
	} inj_state_t;

endpackage

/* rtl/load_req_if.sv */
`timescale 1ns/100ps

interface load_req_if import cbm2_loader_pkg::*;;

	// Held request level, cleared by the producer after taken
	logic      req;
	mem_addr_t addr;
	mem_data_t data;
	logic      prg;
	logic      prg_done;

	// Consumer side
	logic      taken;
	logic      busy;

	modport src (
		output req, addr, data, prg, prg_done,
		input  taken, busy
	);

	modport dst (
		input  req, addr, data, prg, prg_done,
		output taken, busy
	);

endinterface

/* rtl/download_decoder.sv */
`timescale 1ns/100ps

module download_decoder import cbm2_loader_pkg::*; #(
	parameter seg_t ROM_SEG = 9'd15
) (
	input  logic       clk_sys,
	input  logic       RESET,
	input  logic       model,
	input  logic       ioctl_download,
	input  logic       ioctl_wr,
	input  logic [7:0] ioctl_index,
	input  mem_addr_t  ioctl_addr,
	input  mem_data_t  ioctl_data,
	output logic       ioctl_wait,
	load_req_if.src    dn
);

	ld_index_t ld_index;
	logic      is_prg;
	logic      is_rom;
	logic      rom_window;

	logic      old_download;
	logic      done_pend;
	logic      req_r;
	logic      prg_r;
	logic      prg_done_r;
	mem_addr_t load_addr;
	mem_data_t data_r;

	assign ld_index = ioctl_index[5:0];
	assign is_prg   = (ld_index == IDX_PRG);
	assign is_rom   = (ld_index >= IDX_ROME) && (ld_index <= IDX_ROM1);

	// Still inside the ROM segment and below the I/O area
	assign rom_window = (load_addr[24:16] == ROM_SEG) &&
		(load_addr[15:12] != ROM_STOP_NIBBLE);

	// ============================================================
	// Request and end-of-PRG control
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			old_download <= 1'b0;
			done_pend    <= 1'b0;
			req_r        <= 1'b0;
			prg_r        <= 1'b0;
			prg_done_r   <= 1'b0;
		end else begin
			old_download <= ioctl_download;
			prg_done_r   <= 1'b0;

			if (dn.taken)
				req_r <= 1'b0;

			if (old_download && !ioctl_download && is_prg)
				done_pend <= 1'b1;

			// Hold the end marker back until the last body byte has moved on
			if (done_pend && !req_r && !dn.busy) begin
				prg_done_r <= 1'b1;
				done_pend  <= 1'b0;
			end

			if (ioctl_wr) begin
				if (is_prg && ioctl_addr >= 25'd2) begin
					req_r <= 1'b1;
					prg_r <= 1'b1;
				end else if (is_rom && (ioctl_addr == 25'd0 || rom_window)) begin
					req_r <= 1'b1;
					prg_r <= 1'b0;
				end
			end
		end
	end

	// ============================================================
	// Address and data
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (dn.taken)
			load_addr <= load_addr + 1'b1;

		if (ioctl_wr) begin
			data_r <= ioctl_data;
			if (is_prg) begin
				// Two-byte header, low byte first
				if (ioctl_addr == 25'd0) begin
					load_addr[24:16] <= model ? 9'd1 : 9'd0;
					load_addr[7:0]   <= ioctl_data;
				end else if (ioctl_addr == 25'd1) begin
					load_addr[15:8] <= ioctl_data;
				end
			end else if (is_rom && ioctl_addr == 25'd0) begin
				load_addr <= {ROM_SEG, ROM_BASE[ld_index]};
			end
		end
	end

	assign dn.req      = req_r;
	assign dn.addr     = load_addr;
	assign dn.data     = data_r;
	assign dn.prg      = prg_r;
	assign dn.prg_done = prg_done_r;

	// Host is held off while a byte is pending here or downstream is full
	assign ioctl_wait = req_r | dn.busy;

endmodule

/* rtl/basic_pointer_injector.sv */
`timescale 1ns/100ps

module basic_pointer_injector import cbm2_loader_pkg::*; #(
	parameter seg_t ROM_SEG = 9'd15
) (
	input  logic    clk_sys,
	input  logic    RESET,
	load_req_if.dst up,
	load_req_if.src dn
);

	inj_state_t  state;
	logic        accept;
	logic        out_valid;
	logic        hold_valid;
	logic        hold_prg;
	mem_addr_t   hold_addr;
	mem_data_t   hold_data;
	logic        have_start;
	logic        seq_done;
	logic [15:0] start_addr;
	logic [15:0] end_addr;
	logic [7:0]  ptr_off;
	mem_data_t   ptr_data;

	assign accept    = (state == PASS) && up.req && !hold_valid;
	assign out_valid = hold_valid || (state != PASS);

	assign up.taken = accept;
	assign up.busy  = out_valid;

	// Pointer byte for the current injection step
	always_comb begin
		case (state)
			PTR_START_LO: begin
				ptr_off  = PTR_TXTTAB;
				ptr_data = start_addr[7:0];
			end
			PTR_START_HI: begin
				ptr_off  = PTR_TXTTAB + 8'd1;
				ptr_data = start_addr[15:8];
			end
			PTR_END_LO: begin
				ptr_off  = PTR_TXTEND;
				ptr_data = end_addr[7:0];
			end
			PTR_END_HI: begin
				ptr_off  = PTR_TXTEND + 8'd1;
				ptr_data = end_addr[15:8];
			end
			default: begin
				ptr_off  = PTR_TXTTAB;
				ptr_data = 8'h00;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= PASS;
			hold_valid <= 1'b0;
			have_start <= 1'b0;
			seq_done   <= 1'b0;
		end else begin
			seq_done <= 1'b0;

			if (state == PASS && dn.taken)
				hold_valid <= 1'b0;
			if (accept)
				hold_valid <= 1'b1;
			if (accept && up.prg)
				have_start <= 1'b1;

			case (state)
				PASS:         if (up.prg_done) state <= PTR_START_LO;
				PTR_START_LO: if (dn.taken) state <= PTR_START_HI;
				PTR_START_HI: if (dn.taken) state <= PTR_END_LO;
				PTR_END_LO:   if (dn.taken) state <= PTR_END_HI;
				PTR_END_HI: begin
					if (dn.taken) begin
						state      <= PASS;
						have_start <= 1'b0;
						seq_done   <= 1'b1;
					end
				end
				default:      state <= PASS;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (accept) begin
			hold_addr <= up.addr;
			hold_data <= up.data;
			hold_prg  <= up.prg;
			// End pointer sits one past the last body byte
			if (up.prg) begin
				if (!have_start)
					start_addr <= up.addr[15:0];
				end_addr <= up.addr[15:0] + 16'd1;
			end
		end
	end

	assign dn.req      = out_valid;
	assign dn.addr     = (state == PASS) ? hold_addr : {ROM_SEG, 8'h00, ptr_off};
	assign dn.data     = (state == PASS) ? hold_data : ptr_data;
	assign dn.prg      = (state == PASS) && hold_prg;
	assign dn.prg_done = seq_done;

endmodule

/* rtl/sdram_io_port.sv */
`timescale 1ns/100ps

module sdram_io_port import cbm2_loader_pkg::*; #(
	parameter seg_t ROM_SEG = 9'd15
) (
	input  logic    clk_sys,
	input  logic    RESET,
	input  logic    io_cycle,
	load_req_if.dst up,
	output mem_addr_t mem_addr,
	output mem_data_t mem_data,
	output logic    mem_ce,
	output logic    mem_we,
	output rom_mask_t rom_loaded
);

	logic io_cycle_d;
	logic io_fall;
	logic io_rise;
	logic take;
	logic real_rom;

	// CPU hands memory over on the falling edge of io_cycle
	assign io_fall = !io_cycle && io_cycle_d;
	assign io_rise = io_cycle && !io_cycle_d;
	assign take    = io_fall && up.req;

	// Blank or erased-looking bytes do not count as ROM content
	assign real_rom = (up.addr[24:16] == ROM_SEG) && (|up.data) && !(&up.data);

	assign up.taken = take;
	assign up.busy  = mem_we;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			io_cycle_d <= 1'b0;
			mem_ce     <= 1'b0;
			mem_we     <= 1'b0;
			rom_loaded <= '0;
		end else begin
			io_cycle_d <= io_cycle;

			if (io_fall) begin
				mem_ce <= 1'b1;
				mem_we <= up.req;
				if (take && real_rom)
					rom_loaded[up.addr[15:13]] <= 1'b1;
			end else if (io_rise) begin
				mem_ce <= 1'b0;
				mem_we <= 1'b0;
			end
		end
	end

	// Write payload, loaded with the request
	always_ff @(posedge clk_sys) begin
		if (take) begin
			mem_addr <= up.addr;
			mem_data <= up.data;
		end
	end

endmodule

/* rtl/cbm2_loader_top.sv */
`timescale 1ns/100ps

module cbm2_loader_top import cbm2_loader_pkg::*; #(
	parameter seg_t ROM_SEG = 9'd15
) (
	input  logic       clk_sys,
	input  logic       RESET,
	input  logic       model,
	input  logic       ioctl_download,
	input  logic [7:0] ioctl_index,
	input  logic       ioctl_wr,
	input  mem_addr_t  ioctl_addr,
	input  mem_data_t  ioctl_data,
	output logic       ioctl_wait,
	input  logic       io_cycle,
	output mem_addr_t  mem_addr,
	output mem_data_t  mem_data,
	output logic       mem_ce,
	output logic       mem_we,
	output rom_mask_t  rom_loaded
);

	load_req_if dec_to_inj ();
	load_req_if inj_to_port ();

	// ============================================================
	// Download bytes to write requests
	// ============================================================

	download_decoder #(.ROM_SEG(ROM_SEG)) u_decoder (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.model          (model),
		.ioctl_download (ioctl_download),
		.ioctl_wr       (ioctl_wr),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.ioctl_wait     (ioctl_wait),
		.dn             (dec_to_inj)
	);

	// Pass-through plus BASIC pointers after a PRG
	basic_pointer_injector #(.ROM_SEG(ROM_SEG)) u_injector (
		.clk_sys (clk_sys),
		.RESET   (RESET),
		.up      (dec_to_inj),
		.dn      (inj_to_port)
	);

	// ============================================================
	// Memory write port
	// ============================================================

	sdram_io_port #(.ROM_SEG(ROM_SEG)) u_port (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.io_cycle   (io_cycle),
		.up         (inj_to_port),
		.mem_addr   (mem_addr),
		.mem_data   (mem_data),
		.mem_ce     (mem_ce),
		.mem_we     (mem_we),
		.rom_loaded (rom_loaded)
	);

endmodule

/* testbench/cbm2_loader_assertions.sv */
`timescale 1ns/100ps

module cbm2_loader_assertions import cbm2_loader_pkg::*; (
	input logic      clk_sys,
	input logic      RESET,
	input logic      req,
	input logic      taken,
	input mem_addr_t addr,
	input mem_data_t data,
	input logic      mem_ce,
	input logic      mem_we
);

	// A write only inside an open memory cycle
	we_inside_ce: assert property (@(posedge clk_sys) disable iff (RESET)
		mem_we |-> mem_ce)
		else $error("mem_we high while mem_ce is low");

	taken_needs_req: assert property (@(posedge clk_sys) disable iff (RESET)
		taken |-> req)
		else $error("taken pulsed without a pending request");

	// Request held with a stable payload until the consumer latches it
	req_held: assert property (@(posedge clk_sys) disable iff (RESET)
		req && !taken |=> req && $stable(addr) && $stable(data))
		else $error("request dropped or changed before taken");

endmodule

bind sdram_io_port cbm2_loader_assertions u_port_checks (
	.clk_sys (clk_sys),
	.RESET   (RESET),
	.req     (up.req),
	.taken   (up.taken),
	.addr    (up.addr),
	.data    (up.data),
	.mem_ce  (mem_ce),
	.mem_we  (mem_we)
);

bind download_decoder cbm2_loader_assertions u_decoder_checks (
	.clk_sys (clk_sys),
	.RESET   (RESET),
	.req     (dn.req),
	.taken   (dn.taken),
	.addr    (dn.addr),
	.data    (dn.data),
	.mem_ce  (1'b0),
	.mem_we  (1'b0)
);

/* testbench/tb_cbm2_loader.sv */
`timescale 1ns/100ps

module tb_cbm2_loader import cbm2_loader_pkg::*;;

	localparam logic [8:0] ROM_SEG  = 9'd15;
	localparam int         NUM_JOBS = 5;

	typedef struct packed {
		logic [7:0]  idx;
		logic        model;
		logic [15:0] count;
		logic [15:0] load;
		logic [7:0]  seed;
		logic        blank;
	} job_t;

	// Host index, model, bytes sent, PRG load address, data XOR, 00/FF only
	job_t jobs [0:NUM_JOBS-1] = '{
		'{8'd8, 1'b0, 16'd32,   16'h0000, 8'h00, 1'b1},
		'{8'd4, 1'b0, 16'd64,   16'h0000, 8'h5A, 1'b0},
		'{8'd3, 1'b0, 16'd4100, 16'h0000, 8'hC3, 1'b0},
		'{8'd9, 1'b0, 16'd22,   16'h0401, 8'h11, 1'b0},
		'{8'd9, 1'b1, 16'd22,   16'h0401, 8'h22, 1'b0}
	};

	logic       clk_sys;
	logic       RESET;
	logic       model;
	logic       ioctl_download;
	logic [7:0] ioctl_index;
	logic       ioctl_wr;
	mem_addr_t  ioctl_addr;
	mem_data_t  ioctl_data;
	logic       ioctl_wait;
	logic       io_cycle;
	mem_addr_t  mem_addr;
	mem_data_t  mem_data;
	logic       mem_ce;
	logic       mem_we;
	rom_mask_t  rom_loaded;

	logic [15:0] io_lfsr   = 16'd70;
	logic [15:0] data_lfsr = 16'd70;
	logic [32:0] exp_q [$];
	rom_mask_t   exp_mask    = '0;
	logic        we_seen     = 1'b0;
	int          errors      = 0;
	int          writes_seen = 0;
	int          cycles      = 0;
	int          cycle_limit = 0;

	cbm2_loader_top #(.ROM_SEG(ROM_SEG)) u_dut (
		.clk_sys        (clk_sys),
		.RESET          (RESET),
		.model          (model),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.ioctl_wait     (ioctl_wait),
		.io_cycle       (io_cycle),
		.mem_addr       (mem_addr),
		.mem_data       (mem_data),
		.mem_ce         (mem_ce),
		.mem_we         (mem_we),
		.rom_loaded     (rom_loaded)
	);

	// ============================================================
	// Random source and helpers
	// ============================================================

	// Taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(inout logic [15:0] state, input int n, output logic [7:0] value);
		value = '0;
		for (int k = 0; k < n; k++) begin
			state = lfsr_next(state);
			value = {value[6:0], state[0]};
		end
	endtask

	function automatic logic [15:0] rom_base(input logic [5:0] idx);
		case (idx)
			6'd8:    return 16'h1000;
			6'd7:    return 16'h2000;
			6'd6:    return 16'h4000;
			6'd5:    return 16'h6000;
			6'd4:    return 16'h8000;
			6'd3:    return 16'hC000;
			6'd2:    return 16'hE000;
			default: return 16'h0000;
		endcase
	endfunction

	function automatic int total_bytes();
		int sum;
		sum = 0;
		for (int j = 0; j < NUM_JOBS; j++)
			sum += int'(jobs[j].count);
		return sum;
	endfunction

	task automatic check_value(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want) begin
			$display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, want);
			errors++;
		end
	endtask

	// ============================================================
	// Reference model
	// ============================================================

	task automatic expect_write(input mem_addr_t addr, input mem_data_t data);
		exp_q.push_back({addr, data});
		if (addr[24:16] == ROM_SEG && data != 8'h00 && data != 8'hFF)
			exp_mask[addr[15:13]] = 1'b1;
	endtask

	task automatic predict_job(input job_t job, input mem_data_t bytes [$]);
		mem_addr_t   cur;
		logic [15:0] end_addr;
		if (job.idx[5:0] == 6'd9) begin
			cur = {(job.model ? 9'd1 : 9'd0), job.load};
			for (int i = 2; i < bytes.size(); i++) begin
				expect_write(cur, bytes[i]);
				cur = cur + 25'd1;
			end
			// Start and end pointers in the ROM segment zero page
			end_addr = job.load + (job.count - 16'd2);
			expect_write({ROM_SEG, 16'h002D}, job.load[7:0]);
			expect_write({ROM_SEG, 16'h002E}, job.load[15:8]);
			expect_write({ROM_SEG, 16'h002F}, end_addr[7:0]);
			expect_write({ROM_SEG, 16'h0030}, end_addr[15:8]);
		end else begin
			cur = {ROM_SEG, rom_base(job.idx[5:0])};
			for (int i = 0; i < bytes.size(); i++) begin
				if (i == 0 || (cur[24:16] == ROM_SEG && cur[15:12] != 4'hD)) begin
					expect_write(cur, bytes[i]);
					cur = cur + 25'd1;
				end
			end
		end
	endtask

	// ============================================================
	// Host side
	// ============================================================

	task automatic wait_ready();
		@(negedge clk_sys);
		while (ioctl_wait)
			@(negedge clk_sys);
	endtask

	task automatic send_byte(input int i, input mem_data_t d);
		wait_ready();
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= mem_addr_t'(i);
		ioctl_data <= d;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b0;
	endtask

	task automatic run_job(input job_t job);
		mem_data_t  bytes [$];
		logic [7:0] bits;
		for (int i = 0; i < int'(job.count); i++) begin
			take_bits(data_lfsr, job.blank ? 1 : 8, bits);
			if (job.idx[5:0] == 6'd9 && i == 0)
				bytes.push_back(job.load[7:0]);
			else if (job.idx[5:0] == 6'd9 && i == 1)
				bytes.push_back(job.load[15:8]);
			else if (job.blank)
				bytes.push_back(bits[0] ? 8'hFF : 8'h00);
			else
				bytes.push_back(bits ^ job.seed);
		end
		predict_job(job, bytes);
		@(posedge clk_sys);
		ioctl_index    <= job.idx;
		model          <= job.model;
		ioctl_download <= 1'b1;
		foreach (bytes[i])
			send_byte(i, bytes[i]);
		wait_ready();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		// Pointer writes may still be on their way
		@(negedge clk_sys);
		while (exp_q.size() != 0 || ioctl_wait)
			@(negedge clk_sys);
		check_value(32'(rom_loaded), 32'(exp_mask), "rom_loaded");
	endtask

	// ============================================================
	// Clock, io_cycle, monitor and timeout
	// ============================================================

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// CPU phases of 1 to 4 cycles each
	initial begin
		logic [7:0] len;
		io_cycle = 1'b1;
		forever begin
			take_bits(io_lfsr, 2, len);
			repeat (int'(len) + 1) @(posedge clk_sys);
			io_cycle <= ~io_cycle;
		end
	end

	always @(negedge clk_sys) begin
		logic [32:0] expected;
		if (mem_we && !we_seen) begin
			writes_seen++;
			if (exp_q.size() == 0) begin
				$display("Unexpected memory write at %0t ns to address %h", $time, mem_addr);
				errors++;
			end else begin
				expected = exp_q.pop_front();
				check_value(32'(mem_addr), 32'(expected[32:8]), "write address");
				check_value(32'(mem_data), 32'(expected[7:0]), "write data");
			end
		end
		we_seen = mem_we;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles == cycle_limit) begin
			$display("Run timed out after %0d cycles, %0d writes never seen", cycles, exp_q.size());
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	// ============================================================
	// Main sequence
	// ============================================================

	initial begin
		RESET          = 1'b1;
		model          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		cycle_limit    = 12 * total_bytes() + 2000;

		repeat (4) @(posedge clk_sys);
		RESET <= 1'b0;
		@(negedge clk_sys);
		check_value(32'(ioctl_wait), 32'd0, "ioctl_wait after reset");
		check_value(32'(mem_ce), 32'd0, "mem_ce after reset");
		check_value(32'(mem_we), 32'd0, "mem_we after reset");
		check_value(32'(rom_loaded), 32'd0, "rom_loaded after reset");

		for (int j = 0; j < NUM_JOBS; j++)
			run_job(jobs[j]);

		if (exp_q.size() != 0) begin
			$display("%0d expected memory writes never happened", exp_q.size());
			errors++;
		end
		$display("Run complete: %0d errors, %0d writes checked", errors, writes_seen);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

/* verilog.f */
rtl/cbm2_loader_pkg.sv
rtl/load_req_if.sv
rtl/download_decoder.sv
rtl/basic_pointer_injector.sv
rtl/sdram_io_port.sv
rtl/cbm2_loader_top.sv
testbench/cbm2_loader_assertions.sv
testbench/tb_cbm2_loader.sv

/* Makefile */
SIM := obj_dir/Vtb_cbm2_loader

.PHONY: all lint clean

all: $(SIM)
	$(SIM) > sim.log 2>&1; cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

$(SIM): verilog.f $(wildcard rtl/*.sv testbench/*.sv)
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		-f verilog.f --top-module tb_cbm2_loader

lint:
	verilator --lint-only -Wall --timing --assert --timescale 1ns/100ps \
		-f verilog.f --top-module tb_cbm2_loader

clean:
	rm -rf obj_dir sim.log
